/* source/pipeline_pkg.sv */
// Shared types for the execute and memory stages
// ALU op class, ALU control, forward select and function codes

package pipeline_pkg;

	// --------------------------------------------------
	// ALU op class from decode
	// --------------------------------------------------
	typedef enum logic [1:0]
	{
		ALU_OP_ADD   = 2'd0, // lw, sw, addi
		ALU_OP_SUB   = 2'd1, // beq compare
		ALU_OP_FUNCT = 2'd2  // R-type, look at funct
	} alu_op_e;

	// --------------------------------------------------
	// ALU control
	// --------------------------------------------------
	typedef enum logic [3:0]
	{
		ALU_ADD     = 4'd0,
		ALU_SUB     = 4'd1,
		ALU_AND     = 4'd2,
		ALU_OR      = 4'd3,
		ALU_SLT     = 4'd7,
		ALU_NOR     = 4'd9,
		ALU_INVALID = 4'd15 // ALU returns 0
	} alu_ctrl_e;

	// Operand source
	typedef enum logic [1:0]
	{
		FWD_REG = 2'd0, // Register file value
		FWD_WB  = 2'd1, // MEM/WB write data
		FWD_MEM = 2'd2  // EX/MEM ALU result
	} fwd_sel_e;

	// R-type function codes
	localparam logic [5:0] FUNCT_ADD = 6'd32;
	localparam logic [5:0] FUNCT_SUB = 6'd34;
	localparam logic [5:0] FUNCT_AND = 6'd36;
	localparam logic [5:0] FUNCT_OR  = 6'd37;
	localparam logic [5:0] FUNCT_NOR = 6'd39;
	localparam logic [5:0] FUNCT_SLT = 6'd42;

endpackage

/* source/forwarding_unit.sv */
// Forwarding unit
// Picks the operand source for rs and rt, newest stage first

module forwarding_unit
(
	input  logic [4:0]             rs,
	input  logic [4:0]             rt,
	input  logic [4:0]             mem_write_register,
	input  logic                   mem_reg_write,
	input  logic [4:0]             wb_write_register,
	input  logic                   wb_reg_write,
	output pipeline_pkg::fwd_sel_e forward_a,
	output pipeline_pkg::fwd_sel_e forward_b
);

	// Same priority rule for both operands
	function automatic pipeline_pkg::fwd_sel_e select_source(input logic [4:0] src);
		pipeline_pkg::fwd_sel_e sel;
		sel = pipeline_pkg::FWD_REG;
		if (wb_reg_write && (wb_write_register != 5'd0) && (wb_write_register == src))
			sel = pipeline_pkg::FWD_WB;
		if (mem_reg_write && (mem_write_register != 5'd0) && (mem_write_register == src))
			sel = pipeline_pkg::FWD_MEM; // EX/MEM is newer, overrides
		return sel;
	endfunction

	assign forward_a = select_source(rs);
	assign forward_b = select_source(rt);

	// r0 is hardwired, never bypassed
	always_comb
	begin
		assert final ((forward_a == pipeline_pkg::FWD_REG) || (rs != 5'd0))
			else $error("forward_a selected for register zero");
		assert final ((forward_b == pipeline_pkg::FWD_REG) || (rt != 5'd0))
			else $error("forward_b selected for register zero");
	end

endmodule

/* source/alu_control.sv */
// ALU control decode
// Op class plus function code to ALU control

module alu_control
(
	input  pipeline_pkg::alu_op_e   alu_op,
	input  logic [5:0]              funct,
	output pipeline_pkg::alu_ctrl_e alu_ctrl
);

	always_comb
	begin
		case (alu_op)
			pipeline_pkg::ALU_OP_ADD:
				alu_ctrl = pipeline_pkg::ALU_ADD; // Address calc and addi
			pipeline_pkg::ALU_OP_SUB:
				alu_ctrl = pipeline_pkg::ALU_SUB; // Branch compare
			pipeline_pkg::ALU_OP_FUNCT:
			begin
				// R-type
				case (funct)
					pipeline_pkg::FUNCT_ADD: alu_ctrl = pipeline_pkg::ALU_ADD;
					pipeline_pkg::FUNCT_SUB: alu_ctrl = pipeline_pkg::ALU_SUB;
					pipeline_pkg::FUNCT_AND: alu_ctrl = pipeline_pkg::ALU_AND;
					pipeline_pkg::FUNCT_OR:  alu_ctrl = pipeline_pkg::ALU_OR;
					pipeline_pkg::FUNCT_SLT: alu_ctrl = pipeline_pkg::ALU_SLT;
					pipeline_pkg::FUNCT_NOR: alu_ctrl = pipeline_pkg::ALU_NOR;
					default:                 alu_ctrl = pipeline_pkg::ALU_INVALID;
				endcase
			end
			default:
				alu_ctrl = pipeline_pkg::ALU_INVALID; // Unused class
		endcase
	end

endmodule

/* source/alu.sv */
// 32-bit integer ALU
// Result plus zero flag

module alu
(
	input  logic [31:0]             op_a,
	input  logic [31:0]             op_b,
	input  pipeline_pkg::alu_ctrl_e alu_ctrl,
	output logic [31:0]             result,
	output logic                    zero
);

	always_comb
	begin
		case (alu_ctrl)
			pipeline_pkg::ALU_ADD:
				result = op_a + op_b;
			pipeline_pkg::ALU_SUB:
				result = op_a - op_b;
			pipeline_pkg::ALU_AND:
				result = op_a & op_b;
			pipeline_pkg::ALU_OR:
				result = op_a | op_b;
			pipeline_pkg::ALU_NOR:
				result = ~(op_a | op_b);
			pipeline_pkg::ALU_SLT:
				// Signed compare
				result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			default:
				result = 32'd0; // Invalid control
		endcase
	end

	// Used by beq through the EX/MEM register
	assign zero = (result == 32'd0);

endmodule

/* source/execute_stage.sv */
// Execute stage
// Forwarding and operand muxes, ALU, destination select, EX/MEM register

module execute_stage
(
	input  logic                  clk,
	input  logic                  rst,
	// ID/EX data
	input  logic [31:0]           data_1,
	input  logic [31:0]           data_2,
	input  logic [31:0]           imm,
	input  logic [4:0]            rs,
	input  logic [4:0]            rt,
	input  logic [4:0]            rd,
	// ID/EX control
	input  logic                  reg_dst,
	input  logic                  alu_src,
	input  pipeline_pkg::alu_op_e alu_op,
	input  logic                  reg_write,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  logic                  mem_to_reg,
	input  logic                  branch,
	// MEM/WB bypass source
	input  logic                  wb_reg_write,
	input  logic [4:0]            wb_write_register,
	input  logic [31:0]           wb_write_data,
	// EX/MEM
	output logic [31:0]           mem_result,
	output logic [31:0]           mem_store_data,
	output logic [4:0]            mem_write_register,
	output logic                  mem_reg_write,
	output logic                  mem_mem_read,
	output logic                  mem_mem_write,
	output logic                  mem_mem_to_reg,
	output logic                  branch_taken
);

	pipeline_pkg::fwd_sel_e  forward_a;
	pipeline_pkg::fwd_sel_e  forward_b;
	pipeline_pkg::alu_ctrl_e alu_ctrl;
	logic [31:0]             op_a;
	logic [31:0]             op_b_fwd; // Also the store data
	logic [31:0]             op_b;
	logic [31:0]             alu_result;
	logic                    alu_zero;
	logic [4:0]              write_register;
	logic                    mem_branch;
	logic                    mem_zero;

	forwarding_unit forwarding_unit_i
	(
		.rs                 (rs),
		.rt                 (rt),
		.mem_write_register (mem_write_register),
		.mem_reg_write      (mem_reg_write),
		.wb_write_register  (wb_write_register),
		.wb_reg_write       (wb_reg_write),
		.forward_a          (forward_a),
		.forward_b          (forward_b)
	);

	// --------------------------------------------------
	// Operand muxes
	// --------------------------------------------------
	always_comb
	begin
		case (forward_a)
			pipeline_pkg::FWD_MEM: op_a = mem_result;
			pipeline_pkg::FWD_WB:  op_a = wb_write_data;
			default:               op_a = data_1;
		endcase
		case (forward_b)
			pipeline_pkg::FWD_MEM: op_b_fwd = mem_result;
			pipeline_pkg::FWD_WB:  op_b_fwd = wb_write_data;
			default:               op_b_fwd = data_2;
		endcase
	end

	assign op_b = alu_src ? imm : op_b_fwd;           // Immediate only on the ALU side
	assign write_register = reg_dst ? rd : rt; // R-type writes rd

	alu_control alu_control_i
	(
		.alu_op   (alu_op),
		.funct    (imm[5:0]), // funct rides in the low imm bits
		.alu_ctrl (alu_ctrl)
	);

	alu alu_i
	(
		.op_a     (op_a),
		.op_b     (op_b),
		.alu_ctrl (alu_ctrl),
		.result   (alu_result),
		.zero     (alu_zero)
	);

	// --------------------------------------------------
	// EX/MEM register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_result         <= 32'd0;
			mem_store_data     <= 32'd0;
			mem_write_register <= 5'd0;
			mem_reg_write      <= 1'b0;
			mem_mem_read       <= 1'b0;
			mem_mem_write      <= 1'b0;
			mem_mem_to_reg     <= 1'b0;
			mem_branch         <= 1'b0;
			mem_zero           <= 1'b0;
		end
		else
		begin
			mem_result         <= alu_result;
			mem_store_data     <= op_b_fwd;
			mem_write_register <= write_register;
			mem_reg_write      <= reg_write;
			mem_mem_read       <= mem_read;
			mem_mem_write      <= mem_write;
			mem_mem_to_reg     <= mem_to_reg;
			mem_branch         <= branch;
			mem_zero           <= alu_zero;
		end
	end

	assign branch_taken = mem_branch & mem_zero; // beq resolves in MEM

	// Load and store are exclusive in EX/MEM
	assert property (@(posedge clk) disable iff (rst) !(mem_mem_read && mem_mem_write))
		else $error("EX/MEM holds load and store together");

	// A store reaches MEM with no register writeback
	assert property (@(posedge clk) disable iff (rst) !(mem_mem_write && mem_reg_write))
		else $error("Store carries reg_write into EX/MEM");

endmodule

/* source/memory_stage.sv */
// Memory stage
// Word-addressed data memory and the MEM/WB register

module memory_stage
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] mem_result,
	input  logic [31:0] mem_store_data,
	input  logic [4:0]  mem_write_register,
	input  logic        mem_reg_write,
	input  logic        mem_mem_read,
	input  logic        mem_mem_write,
	input  logic        mem_mem_to_reg,
	output logic        wb_reg_write,
	output logic [4:0]  wb_write_register,
	output logic [31:0] wb_write_data
);

	localparam int ADDR_W = $clog2(DMEM_WORDS);

	logic [31:0]       dmem [DMEM_WORDS];
	logic [ADDR_W-1:0] word_index;
	logic [31:0]       load_data;

	// Byte address to word, wraps at the array size
	assign word_index = mem_result[ADDR_W+1:2];
	assign load_data  = dmem[word_index]; // Async read

	// --------------------------------------------------
	// Data memory write port
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst && mem_mem_write)
			dmem[word_index] <= mem_store_data;
	end

	// --------------------------------------------------
	// MEM/WB register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_reg_write      <= 1'b0;
			wb_write_register <= 5'd0;
			wb_write_data     <= 32'd0;
		end
		else
		begin
			wb_reg_write      <= mem_reg_write;
			wb_write_register <= mem_write_register;
			wb_write_data     <= mem_mem_to_reg ? load_data : mem_result; // lw or ALU
		end
	end

	// Loads and stores only on word boundaries
	assert property (@(posedge clk) disable iff (rst)
		(mem_mem_read || mem_mem_write) |-> (mem_result[1:0] == 2'b00))
		else $error("Unaligned data memory access at %h", mem_result);

endmodule

/* source/execute_top.sv */
// Execute and memory top level
// MEM/WB values loop back into execute as the second bypass source

module execute_top
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [31:0]           data_1,
	input  logic [31:0]           data_2,
	input  logic [31:0]           imm,
	input  logic [4:0]            rs,
	input  logic [4:0]            rt,
	input  logic [4:0]            rd,
	input  logic                  reg_dst,
	input  logic                  alu_src,
	input  pipeline_pkg::alu_op_e alu_op,
	input  logic                  reg_write,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  logic                  mem_to_reg,
	input  logic                  branch,
	output logic                  branch_taken,
	output logic                  wb_reg_write,
	output logic [4:0]            wb_write_register,
	output logic [31:0]           wb_write_data
);

	// EX/MEM
	logic [31:0] mem_result;
	logic [31:0] mem_store_data;
	logic [4:0]  mem_write_register;
	logic        mem_reg_write;
	logic        mem_mem_read;
	logic        mem_mem_write;
	logic        mem_mem_to_reg;

	execute_stage execute_stage_i
	(
		.clk                (clk),
		.rst                (rst),
		.data_1             (data_1),
		.data_2             (data_2),
		.imm                (imm),
		.rs                 (rs),
		.rt                 (rt),
		.rd                 (rd),
		.reg_dst            (reg_dst),
		.alu_src            (alu_src),
		.alu_op             (alu_op),
		.reg_write          (reg_write),
		.mem_read           (mem_read),
		.mem_write          (mem_write),
		.mem_to_reg         (mem_to_reg),
		.branch             (branch),
		.wb_reg_write       (wb_reg_write),      // Bypass from MEM/WB
		.wb_write_register  (wb_write_register),
		.wb_write_data      (wb_write_data),
		.mem_result         (mem_result),
		.mem_store_data     (mem_store_data),
		.mem_write_register (mem_write_register),
		.mem_reg_write      (mem_reg_write),
		.mem_mem_read       (mem_mem_read),
		.mem_mem_write      (mem_mem_write),
		.mem_mem_to_reg     (mem_mem_to_reg),
		.branch_taken       (branch_taken)
	);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_stage_i
	(
		.clk                (clk),
		.rst                (rst),
		.mem_result         (mem_result),
		.mem_store_data     (mem_store_data),
		.mem_write_register (mem_write_register),
		.mem_reg_write      (mem_reg_write),
		.mem_mem_read       (mem_mem_read),
		.mem_mem_write      (mem_mem_write),
		.mem_mem_to_reg     (mem_mem_to_reg),
		.wb_reg_write       (wb_reg_write),
		.wb_write_register  (wb_write_register),
		.wb_write_data      (wb_write_data)
	);

endmodule

/* bench/execute_checker.sv */
// Reference model and scoreboard for the execute and memory stages
// In-order register file and data memory, checks writeback and branch_taken

module execute_checker
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        running,  // Rows are being applied
	input  string       row_name,
	input  logic [4:0]  rs,
	input  logic [4:0]  rt,
	input  logic [4:0]  rd,
	input  logic [31:0] imm,
	input  logic        reg_dst,
	input  logic        alu_src,
	input  logic [1:0]  alu_op,
	input  logic        reg_write,
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic        mem_to_reg,
	input  logic        branch,
	input  logic        branch_taken,
	input  logic        wb_reg_write,
	input  logic [4:0]  wb_write_register,
	input  logic [31:0] wb_write_data,
	output int          error_count,
	output int          check_count,
	output int          pending
);

	localparam int ADDR_W     = $clog2(DMEM_WORDS);
	localparam int MISS_LIMIT = 3; // Cycles a late writeback may lag

	logic [31:0] arch_regs [32];
	logic [31:0] mem_model [DMEM_WORDS];
	integer      seed;
	int          cycle;

	// Expected results in flight
	string       wb_name [$];
	bit          wb_wr [$];
	logic [4:0]  wb_dst [$];
	logic [31:0] wb_data [$];
	int          wb_due [$];
	string       br_name [$];
	bit          br_taken [$];
	int          br_due [$];

	initial
	begin
		// Same seed and order as the bench register file
		seed = 32'hac0a079e;
		arch_regs[0] = 32'd0;
		for (int i = 1; i < 32; i++)
			arch_regs[i] = $random(seed);
		error_count = 0;
		check_count = 0;
		pending     = 0;
		cycle       = 0;
	end

	// Oldest expected writeback is done with
	task automatic drop_expected_wb();
		void'(wb_name.pop_front());
		void'(wb_wr.pop_front());
		void'(wb_dst.pop_front());
		void'(wb_data.pop_front());
		void'(wb_due.pop_front());
	endtask

	// --------------------------------------------------
	// Architectural model, one row per rising edge
	// --------------------------------------------------
	always @(posedge clk)
	begin : model
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       op_b;
		logic [31:0]       res;
		logic [31:0]       wdata;
		logic [4:0]        dst;
		logic [ADDR_W-1:0] idx;
		if (rst)
		begin
			wb_name.delete();
			wb_wr.delete();
			wb_dst.delete();
			wb_data.delete();
			wb_due.delete();
			br_name.delete();
			br_taken.delete();
			br_due.delete();
		end
		else if (running)
		begin
			a    = arch_regs[rs];
			b    = arch_regs[rt];
			op_b = alu_src ? imm : b;
			case (alu_op)
				pipeline_pkg::ALU_OP_ADD: res = a + op_b;
				pipeline_pkg::ALU_OP_SUB: res = a - op_b;
				pipeline_pkg::ALU_OP_FUNCT:
				begin
					case (imm[5:0])
						6'd32: res = a + op_b;
						6'd34: res = a - op_b;
						6'd36: res = a & op_b;
						6'd37: res = a | op_b;
						6'd42: res = ($signed(a) < $signed(op_b)) ? 32'd1 : 32'd0;
						6'd39: res = ~(a | op_b);
						default: res = 32'd0; // Unlisted funct
					endcase
				end
				default: res = 32'd0;
			endcase
			idx = res[ADDR_W+1:2];
			if (mem_write)
				mem_model[idx] = b; // Store data is the rt value
			wdata = mem_to_reg ? mem_model[idx] : res;
			dst   = reg_dst ? rd : rt;
			if (reg_write && dst != 5'd0)
				arch_regs[dst] = wdata; // r0 stays 0

			br_name.push_back(row_name);
			br_taken.push_back(branch && (res == 32'd0));
			br_due.push_back(cycle + 1);
			wb_name.push_back(row_name);
			wb_wr.push_back(reg_write);
			wb_dst.push_back(dst);
			wb_data.push_back(wdata);
			wb_due.push_back(cycle + 2);
		end
	end

	// --------------------------------------------------
	// Output compare on falling edges
	// --------------------------------------------------
	always @(negedge clk)
	begin
		cycle++;
		// Branch, one cycle after the row
		if (br_due.size() > 0 && br_due[0] == cycle)
		begin
			check_count++;
			if (branch_taken !== br_taken[0])
			begin
				error_count++;
				$display("Fail %s branch_taken: expected %0b, actual %0b",
					br_name[0], br_taken[0], branch_taken);
			end
			void'(br_name.pop_front());
			void'(br_taken.pop_front());
			void'(br_due.pop_front());
		end
		else if (branch_taken !== 1'b0)
		begin
			error_count++; // Covers reset too
			$display("branch_taken was set with no branch in flight at cycle %0d", cycle);
		end

		// Writeback, two cycles after the row
		if (wb_due.size() > 0 && wb_due[0] <= cycle)
		begin
			if (!wb_wr[0])
			begin
				check_count++;
				if (wb_reg_write !== 1'b0)
				begin
					error_count++;
					$display("Fail %s wb_reg_write: expected 0, actual %0b",
						wb_name[0], wb_reg_write);
				end
				drop_expected_wb();
			end
			else if (wb_reg_write === 1'b1 && wb_write_register == wb_dst[0])
			begin
				check_count++;
				if (wb_write_data !== wb_data[0])
				begin
					error_count++;
					$display("Fail %s r%0d: expected %h, actual %h",
						wb_name[0], wb_dst[0], wb_data[0], wb_write_data);
				end
				drop_expected_wb();
			end
			else if (cycle - wb_due[0] >= MISS_LIMIT)
			begin
				// Gave up waiting
				error_count++;
				$display("Row %s never wrote back to register %0d", wb_name[0], wb_dst[0]);
				drop_expected_wb();
			end
		end
		else if (wb_reg_write !== 1'b0)
		begin
			error_count++;
			$display("Writeback to register %0d appeared with no row in flight at cycle %0d",
				wb_write_register, cycle);
		end
		pending = wb_due.size() + br_due.size();
	end

endmodule

/* bench/execute_tb.sv */
// Testbench for execute_top
// Clock, reset, register file model and an instruction table applied in a loop

module execute_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_ROWS    = 64;
	localparam int DRAIN_LIMIT = 20;

	logic                  clk;
	logic                  rst;
	logic [31:0]           data_1;
	logic [31:0]           data_2;
	logic [31:0]           imm;
	logic [4:0]            rs;
	logic [4:0]            rt;
	logic [4:0]            rd;
	logic                  reg_dst;
	logic                  alu_src;
	pipeline_pkg::alu_op_e alu_op;
	logic                  reg_write;
	logic                  mem_read;
	logic                  mem_write;
	logic                  mem_to_reg;
	logic                  branch;
	logic                  branch_taken;
	logic                  wb_reg_write;
	logic [4:0]            wb_write_register;
	logic [31:0]           wb_write_data;
	logic                  running;
	string                 row_name;
	int                    error_count;
	int                    check_count;
	int                    pending;
	bit                    timed_out;
	int                    wait_cycles;

	logic [31:0] regs [32]; // Register file model
	integer      seed;

	// Instruction table
	string                 t_name [MAX_ROWS];
	logic [4:0]            t_rs [MAX_ROWS];
	logic [4:0]            t_rt [MAX_ROWS];
	logic [4:0]            t_rd [MAX_ROWS];
	logic [31:0]           t_imm [MAX_ROWS];
	logic [7:0]            t_ctrl [MAX_ROWS]; // reg_dst alu_src reg_write mem_read ...
	pipeline_pkg::alu_op_e t_op [MAX_ROWS];
	int                    row_count;

	execute_top #(.DMEM_WORDS(64)) execute_top_i
	(
		.clk (clk), .rst (rst), .data_1 (data_1), .data_2 (data_2), .imm (imm),
		.rs (rs), .rt (rt), .rd (rd), .reg_dst (reg_dst), .alu_src (alu_src),
		.alu_op (alu_op), .reg_write (reg_write), .mem_read (mem_read),
		.mem_write (mem_write), .mem_to_reg (mem_to_reg), .branch (branch),
		.branch_taken (branch_taken), .wb_reg_write (wb_reg_write),
		.wb_write_register (wb_write_register), .wb_write_data (wb_write_data)
	);

	execute_checker #(.DMEM_WORDS(64)) execute_checker_i
	(
		.clk (clk), .rst (rst), .running (running), .row_name (row_name),
		.rs (rs), .rt (rt), .rd (rd), .imm (imm), .reg_dst (reg_dst),
		.alu_src (alu_src), .alu_op (alu_op), .reg_write (reg_write),
		.mem_read (mem_read), .mem_write (mem_write), .mem_to_reg (mem_to_reg),
		.branch (branch), .branch_taken (branch_taken), .wb_reg_write (wb_reg_write),
		.wb_write_register (wb_write_register), .wb_write_data (wb_write_data),
		.error_count (error_count), .check_count (check_count), .pending (pending)
	);

	always #10 clk = ~clk;

	// Writeback into the register file model
	always @(posedge clk)
	begin
		if (!rst && wb_reg_write && wb_write_register != 5'd0)
			regs[wb_write_register] <= wb_write_data;
	end

	// --------------------------------------------------
	// Table building
	// --------------------------------------------------
	// ctrl bits: reg_dst, alu_src, reg_write, mem_read, mem_write, mem_to_reg, branch
	task automatic add_row(input string name, input logic [4:0] r_s, input logic [4:0] r_t,
		input logic [4:0] r_d, input logic [31:0] value, input logic [7:0] ctrl,
		input pipeline_pkg::alu_op_e op);
		t_name[row_count] = name;
		t_rs[row_count]   = r_s;
		t_rt[row_count]   = r_t;
		t_rd[row_count]   = r_d;
		t_imm[row_count]  = value;
		t_ctrl[row_count] = ctrl;
		t_op[row_count]   = op;
		row_count++;
	endtask

	task automatic rtype_row(input string name, input logic [4:0] r_s, input logic [4:0] r_t,
		input logic [4:0] r_d, input logic [5:0] funct);
		add_row(name, r_s, r_t, r_d, {26'd0, funct}, 8'b0101_0000, pipeline_pkg::ALU_OP_FUNCT);
	endtask

	task automatic addi_row(input string name, input logic [4:0] r_s, input logic [4:0] r_t,
		input logic [31:0] value);
		add_row(name, r_s, r_t, 5'd0, value, 8'b0011_0000, pipeline_pkg::ALU_OP_ADD);
	endtask

	task automatic build_table();
		row_count = 0;
		rtype_row("add", 5'd1, 5'd2, 5'd3, 6'd32);
		rtype_row("sub", 5'd5, 5'd6, 5'd4, 6'd34);
		rtype_row("and", 5'd8, 5'd9, 5'd7, 6'd36);
		rtype_row("or", 5'd11, 5'd12, 5'd10, 6'd37);
		rtype_row("slt", 5'd14, 5'd15, 5'd13, 6'd42);
		rtype_row("nor", 5'd17, 5'd18, 5'd16, 6'd39);
		addi_row("addi", 5'd1, 5'd19, 32'd100);
		rtype_row("bad_funct", 5'd1, 5'd2, 5'd20, 6'd0); // Writes 0
		add_row("bubble_a", 5'd0, 5'd0, 5'd0, 32'd0, 8'd0, pipeline_pkg::ALU_OP_ADD);
		// Back-to-back, EX/MEM forward on rs then rt
		addi_row("dep_base", 5'd1, 5'd22, 32'd5);
		rtype_row("fwd_mem_rs", 5'd22, 5'd2, 5'd23, 6'd32);
		rtype_row("fwd_mem_rt", 5'd1, 5'd23, 5'd24, 6'd32);
		// Two apart, MEM/WB forward on both
		addi_row("wb_base", 5'd0, 5'd25, 32'd7);
		add_row("bubble_b", 5'd0, 5'd0, 5'd0, 32'd0, 8'd0, pipeline_pkg::ALU_OP_ADD);
		rtype_row("fwd_wb", 5'd25, 5'd25, 5'd26, 6'd32);
		// Both stages match r27, newer wins
		addi_row("old_r27", 5'd0, 5'd27, 32'd11);
		addi_row("new_r27", 5'd0, 5'd27, 32'd22);
		rtype_row("fwd_newest", 5'd27, 5'd0, 5'd28, 6'd32);
		// Store then load, same address
		addi_row("addr", 5'd0, 5'd29, 32'd64);
		addi_row("st_data", 5'd0, 5'd30, 32'h1234);
		add_row("sw", 5'd29, 5'd30, 5'd0, 32'd8, 8'b0010_0100, pipeline_pkg::ALU_OP_ADD);
		add_row("lw", 5'd29, 5'd31, 5'd0, 32'd8, 8'b0011_1010, pipeline_pkg::ALU_OP_ADD);
		add_row("bubble_c", 5'd0, 5'd0, 5'd0, 32'd0, 8'd0, pipeline_pkg::ALU_OP_ADD);
		add_row("bubble_d", 5'd0, 5'd0, 5'd0, 32'd0, 8'd0, pipeline_pkg::ALU_OP_ADD);
		rtype_row("use_load", 5'd31, 5'd0, 5'd2, 6'd37);
		// beq, equal then unequal
		addi_row("beq_a", 5'd0, 5'd5, 32'd9);
		addi_row("beq_b", 5'd0, 5'd6, 32'd9);
		add_row("beq_eq", 5'd5, 5'd6, 5'd0, 32'd0, 8'b0000_0001, pipeline_pkg::ALU_OP_SUB);
		add_row("beq_ne", 5'd5, 5'd7, 5'd0, 32'd0, 8'b0000_0001, pipeline_pkg::ALU_OP_SUB);
		// Write to r0, dependents read 0
		addi_row("write_r0", 5'd1, 5'd0, 32'd77);
		rtype_row("r0_dep_a", 5'd0, 5'd0, 5'd8, 6'd32);
		rtype_row("r0_dep_b", 5'd0, 5'd1, 5'd9, 6'd37);
	endtask

	// Drive one row, operands straight from the register file model
	task automatic drive_row(input int i);
		row_name   = t_name[i];
		rs         = t_rs[i];
		rt         = t_rt[i];
		rd         = t_rd[i];
		imm        = t_imm[i];
		data_1     = regs[t_rs[i]]; // May be stale
		data_2     = regs[t_rt[i]];
		reg_dst    = t_ctrl[i][6];
		alu_src    = t_ctrl[i][5];
		reg_write  = t_ctrl[i][4];
		mem_read   = t_ctrl[i][3];
		mem_write  = t_ctrl[i][2];
		mem_to_reg = t_ctrl[i][1];
		branch     = t_ctrl[i][0];
		alu_op     = t_op[i];
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		running   = 1'b0;
		timed_out = 1'b0;
		seed      = 32'hac0a079e;
		regs[0]   = 32'd0;
		for (int i = 1; i < 32; i++)
			regs[i] = $random(seed);
		build_table();
		// Idle row just past the table
		t_name[row_count] = "idle";
		t_rs[row_count]   = 5'd0;
		t_rt[row_count]   = 5'd0;
		t_rd[row_count]   = 5'd0;
		t_imm[row_count]  = 32'd0;
		t_ctrl[row_count] = 8'd0;
		t_op[row_count]   = pipeline_pkg::ALU_OP_ADD;
		drive_row(row_count); // All inputs quiet during reset

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst     = 1'b0;
		running = 1'b1;
		for (int i = 0; i < row_count; i++)
		begin
			drive_row(i);
			@(negedge clk);
		end
		drive_row(row_count);
		running = 1'b0;

		// Let the last rows reach writeback
		wait_cycles = 0;
		while (pending != 0 && wait_cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (pending != 0)
		begin
			timed_out = 1'b1;
			$display("Timed out with %0d results still in flight", pending);
		end
		repeat (2) @(posedge clk);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* sources.f */
source/pipeline_pkg.sv
source/forwarding_unit.sv
source/alu_control.sv
source/alu.sv
source/execute_stage.sv
source/memory_stage.sv
source/execute_top.sv
bench/execute_checker.sv
bench/execute_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module execute_tb \
	-o execute_sim > build.log 2>&1 \
	&& ./obj_dir/execute_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Finished with no errors$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
